//--- Makefile
TOP = tb_hart_sched

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x 'TESTBENCH PASSED' > /dev/null

lint:
	verilator --lint-only -Wall --timing --top-module hart_sched_top -f list.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- hart_pkg.sv
// hart scheduler package with register map, AXI response codes and id width helper
package hart_pkg;

    // AXI4-Lite bus geometry
    localparam int axi_addr_w = 4;
    localparam int axi_data_w = 32;

    // register byte offsets
    localparam logic [axi_addr_w-1:0] reg_active_off  = 4'h0;  // active-hart mask, rw
    localparam logic [axi_addr_w-1:0] reg_primary_off = 4'h4;  // primary hart id, rw
    localparam logic [axi_addr_w-1:0] reg_issue_off   = 4'h8;  // last issue one-hot, ro

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // id width for a given hart count, never below one bit
    function automatic int hart_id_w(int n);
        int w;
        if (n > 1) begin
            w = $clog2(n);
        end else begin
            w = 1;
        end
        return w;
    endfunction

endpackage

//--- hart_sched_top.sv
// hart scheduler top, register block plus hart switch and minor hart selector
`timescale 1ns/1ps

module hart_sched_top #(
    parameter int num_harts = 4
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [hart_pkg::axi_addr_w-1:0]               awaddr,
    input  logic                                          awvalid,
    output logic                                          awready,
    input  logic [hart_pkg::axi_data_w-1:0]               wdata,
    input  logic [hart_pkg::axi_data_w/8-1:0]             wstrb,
    input  logic                                          wvalid,
    output logic                                          wready,
    output logic [1:0]                                    bresp,
    output logic                                          bvalid,
    input  logic                                          bready,
    input  logic [hart_pkg::axi_addr_w-1:0]               araddr,
    input  logic                                          arvalid,
    output logic                                          arready,
    output logic [hart_pkg::axi_data_w-1:0]               rdata,
    output logic [1:0]                                    rresp,
    output logic                                          rvalid,
    input  logic                                          rready,
    input  logic                                          hart_kill,
    input  logic [hart_pkg::hart_id_w(num_harts)-1:0]     kill_hart,
    input  logic                                          is_branch,
    input  logic                                          is_load,
    input  logic [hart_pkg::hart_id_w(num_harts)-1:0]     decode_hart,
    input  logic                                          ic_miss,
    input  logic                                          ic_fin,
    input  logic                                          dc_miss,
    input  logic                                          dc_fin,
    output logic [num_harts-1:0]                          issue_hart,
    output logic                                          ic_stall,
    output logic                                          dc_stall,
    output logic                                          ic_flush,
    output logic                                          dc_flush
);
    logic [num_harts-1:0] active_mask;
    logic [num_harts-1:0] primary_onehot;
    logic [num_harts-1:0] last_issue;
    logic [num_harts-1:0] minor_mask;
    logic [num_harts-1:0] minor_pick;
    logic                 pick_taken;

    // all block ports share names with the nets here
    hart_state_regs #(.num_harts(num_harts)) u_regs (.*);

    hart_switch #(.num_harts(num_harts)) u_switch (.*);

    minor_hart_sel #(.num_harts(num_harts)) u_minor_sel (.*);

endmodule

//--- hart_state_regs.sv
// hart state registers, AXI4-Lite slave for active mask, primary hart and issue readback
`timescale 1ns/1ps

module hart_state_regs #(
    parameter int num_harts = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [hart_pkg::axi_addr_w-1:0]     awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [hart_pkg::axi_data_w-1:0]     wdata,
    input  logic [hart_pkg::axi_data_w/8-1:0]   wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [hart_pkg::axi_addr_w-1:0]     araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [hart_pkg::axi_data_w-1:0]     rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,
    input  logic [num_harts-1:0]                last_issue,
    output logic [num_harts-1:0]                active_mask,
    output logic [num_harts-1:0]                primary_onehot
);
    import hart_pkg::*;

    localparam int id_w = hart_id_w(num_harts);

    logic [id_w-1:0]       primary_id;
    logic                  wr_en;
    logic                  rd_en;
    logic                  wr_hit_active;
    logic                  wr_hit_primary;
    logic [axi_data_w-1:0] rd_value;
    logic                  rd_err;

    // address and data accepted together, one write outstanding
    assign wr_en   = awvalid && wvalid && !bvalid;
    assign awready = wr_en;
    assign wready  = wr_en;

    assign arready = !rvalid;  // one read outstanding
    assign rd_en   = arvalid && arready;

    assign wr_hit_active  = (awaddr == reg_active_off);
    assign wr_hit_primary = (awaddr == reg_primary_off);

    always_ff @(posedge clk) begin
        if (rst) begin
            active_mask <= '0;
            primary_id  <= '0;
        end else if (wr_en && wstrb[0]) begin  // all fields sit in byte 0
            if (wr_hit_active) active_mask <= wdata[num_harts-1:0];
            if (wr_hit_primary) primary_id <= wdata[id_w-1:0];
        end
    end

    assign primary_onehot = num_harts'(1) << primary_id;

    // write response channel
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_en) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            bresp <= (wr_hit_active || wr_hit_primary) ? resp_okay : resp_slverr;
        end
    end

    // read mux, issue register is read only
    always_comb begin
        rd_value = '0;
        rd_err   = 1'b0;
        case (araddr)
            reg_active_off:  rd_value[num_harts-1:0] = active_mask;
            reg_primary_off: rd_value[id_w-1:0]      = primary_id;
            reg_issue_off:   rd_value[num_harts-1:0] = last_issue;
            default:         rd_err                  = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_en) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= rd_value;
            rresp <= rd_err ? resp_slverr : resp_okay;
        end
    end

    // responses stay put under back-pressure
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

//--- hart_switch.sv
// hart switch, picks the issuing hart each cycle and turns cache misses into stall or flush
`timescale 1ns/1ps

module hart_switch #(
    parameter int num_harts = 4
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [num_harts-1:0]                          active_mask,
    input  logic [num_harts-1:0]                          primary_onehot,
    input  logic [num_harts-1:0]                          minor_pick,
    input  logic                                          hart_kill,
    input  logic [hart_pkg::hart_id_w(num_harts)-1:0]     kill_hart,
    input  logic                                          is_branch,
    input  logic                                          is_load,
    input  logic [hart_pkg::hart_id_w(num_harts)-1:0]     decode_hart,
    input  logic                                          ic_miss,
    input  logic                                          ic_fin,
    input  logic                                          dc_miss,
    input  logic                                          dc_fin,
    output logic [num_harts-1:0]                          minor_mask,
    output logic                                          pick_taken,
    output logic [num_harts-1:0]                          issue_hart,
    output logic [num_harts-1:0]                          last_issue,
    output logic                                          ic_stall,
    output logic                                          dc_stall,
    output logic                                          ic_flush,
    output logic                                          dc_flush
);
    import hart_pkg::*;

    localparam int id_w = hart_id_w(num_harts);

    logic [num_harts-1:0] kill_onehot;
    logic [num_harts-1:0] decode_onehot;
    logic [num_harts-1:0] rotated;
    logic [id_w:0]        active_cnt;
    logic                 all_active;
    logic                 three_active;
    logic                 single;
    logic                 kill_prim;
    logic                 decode_prim;
    logic                 rule5_hit;
    logic                 follow_minor;  // issue a minor hart this cycle
    logic                 follow_twice;  // and once more after that

    assign minor_mask = active_mask & ~primary_onehot;

    assign kill_onehot   = num_harts'(1) << kill_hart;
    assign decode_onehot = num_harts'(1) << decode_hart;

    assign kill_prim   = hart_kill && (kill_onehot == primary_onehot);
    assign decode_prim = (is_branch || is_load) && (decode_onehot == primary_onehot);

    // interleave order, wraps from hart 0 (or nothing) to the top hart
    assign rotated = ((last_issue >> 1) == '0) ? num_harts'(1) << (num_harts - 1)
                                               : last_issue >> 1;

    always_comb begin
        active_cnt = '0;
        for (int i = 0; i < num_harts; i++) begin
            active_cnt = active_cnt + (id_w + 1)'(active_mask[i]);
        end
    end

    assign all_active   = &active_mask;
    assign three_active = (active_cnt == (id_w + 1)'(num_harts - 1));
    assign single       = (active_cnt <= (id_w + 1)'(1));

    // issue rules in priority order
    always_comb begin
        issue_hart = primary_onehot;
        pick_taken = 1'b0;
        rule5_hit  = 1'b0;
        if (active_mask == '0) begin
            issue_hart = '0;
        end else if (all_active) begin
            issue_hart = rotated;
        end else if (minor_mask == '0) begin
            issue_hart = primary_onehot;  // primary runs alone
        end else if (kill_prim) begin
            issue_hart = minor_pick;
            pick_taken = 1'b1;
        end else if (decode_prim) begin
            issue_hart = minor_pick;
            pick_taken = 1'b1;
            rule5_hit  = 1'b1;
        end else if (follow_minor) begin
            issue_hart = minor_pick;
            pick_taken = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            follow_minor <= 1'b0;
            follow_twice <= 1'b0;
            last_issue   <= '0;
        end else begin
            follow_minor <= (rule5_hit && (is_load || (is_branch && three_active)))
                            || follow_twice;
            follow_twice <= rule5_hit && is_load && $onehot(minor_mask);  // lone minor hart
            last_issue   <= issue_hart;
        end
    end

    // one hart left means wait out the miss, otherwise flush and switch
    assign ic_stall = single && ic_miss && !dc_fin;
    assign dc_stall = single && dc_miss && !ic_fin;
    assign ic_flush = !single && ic_miss;
    assign dc_flush = !single && dc_miss;

    // with an active primary, issue never leaves the active set
    a_issue_active: assert property (@(posedge clk) disable iff (rst)
        ((primary_onehot & active_mask) != '0) |-> ((issue_hart & ~active_mask) == '0));

endmodule

//--- list.f
hart_pkg.sv
hart_state_regs.sv
minor_hart_sel.sv
hart_switch.sv
hart_sched_top.sv
tb_hart_sched.sv

//--- minor_hart_sel.sv
// minor hart selector, round-robin pick over the non-primary active harts
`timescale 1ns/1ps

module minor_hart_sel #(
    parameter int num_harts = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [num_harts-1:0] minor_mask,
    input  logic                 pick_taken,
    output logic [num_harts-1:0] minor_pick
);
    logic [num_harts-1:0] last_pick;  // one-hot, last hart handed out
    logic [num_harts-1:0] above;
    logic [num_harts-1:0] pool;

    // candidates strictly above the remembered hart
    assign above = minor_mask & ~(last_pick | (last_pick - num_harts'(1)));

    // nothing above, wrap around to the bottom of the mask
    assign pool = (above != '0) ? above : minor_mask;

    assign minor_pick = pool & (~pool + num_harts'(1));  // lowest set bit

    always_ff @(posedge clk) begin
        if (rst) begin
            last_pick <= num_harts'(1) << (num_harts - 1);  // top hart, first pick is lowest
        end else if (pick_taken) begin
            last_pick <= minor_pick;
        end
    end

    // a pick taken by the switch is always a single minor hart
    a_pick_valid: assert property (@(posedge clk) disable iff (rst)
        $onehot0(minor_pick) && ((minor_pick & ~minor_mask) == '0)
        && (pick_taken -> minor_pick != '0));

endmodule

//--- tb_hart_sched.sv
// hart scheduler testbench, directed tests against a cycle reference model
`timescale 1ns/1ps

module tb_hart_sched;
    import hart_pkg::*;

    localparam int max_cycles = 2000;  // roughly four times the test length

    logic clk, rst;
    logic [axi_addr_w-1:0] awaddr, araddr;
    logic [axi_data_w-1:0] wdata, rdata;
    logic [3:0] wstrb;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [1:0] bresp, rresp;
    logic hart_kill, is_branch, is_load, ic_miss, ic_fin, dc_miss, dc_fin;
    logic [1:0] kill_hart, decode_hart;
    logic [3:0] issue_hart;
    logic ic_stall, dc_stall, ic_flush, dc_flush;

    // reference model state
    logic [3:0] m_active, m_last;
    logic [1:0] m_prim;
    logic m_follow, m_twice;
    int m_rem;
    int errors = 0, tests_passed = 0, tests_failed = 0, cyc = 0;
    int seed = 32'h72f4_8437;

    hart_sched_top UUT (.*);

    always #50 clk = ~clk;

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // model runs on every edge, sampled before the DUT registers move
    always @(posedge clk) begin : model
        int cnt, nminor, pick, lid;
        logic [3:0] minor, exp_issue, prim_oh;
        logic taken, r5, single;
        cyc++;
        if (cyc >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end else if (rst) begin
            m_active = '0;
            m_prim   = '0;
            m_last   = '0;
            m_follow = 1'b0;
            m_twice  = 1'b0;
            m_rem    = 3;  // first pick is then the lowest minor hart
        end else begin
            prim_oh = 4'b0001 << m_prim;
            minor = m_active & ~prim_oh;
            cnt = 0;
            nminor = 0;
            lid = -1;
            pick = -1;
            for (int h = 3; h >= 0; h--) begin
                cnt += m_active[h];
                nminor += minor[h];
                if (m_last[h]) lid = h;
                if (minor[h] && h > m_rem) pick = h;  // ends on the lowest one above
            end
            if (pick < 0) begin
                for (int h = 3; h >= 0; h--) begin
                    if (minor[h]) pick = h;
                end
            end
            taken = 1'b0;
            r5 = 1'b0;
            exp_issue = prim_oh;
            if (cnt == 0) begin
                exp_issue = '0;
            end else if (cnt == 4) begin
                exp_issue = (lid <= 0) ? 4'b1000 : 4'b0001 << (lid - 1);
            end else if (nminor == 0) begin
                exp_issue = prim_oh;
            end else if ((hart_kill && kill_hart == m_prim) ||
                         ((is_branch || is_load) && decode_hart == m_prim) || m_follow) begin
                exp_issue = 4'b0001 << pick;
                taken = 1'b1;
                r5 = !(hart_kill && kill_hart == m_prim) &&
                     (is_branch || is_load) && decode_hart == m_prim;
            end
            single = (cnt <= 1);
            expect_eq("issue_hart", issue_hart, exp_issue);
            expect_eq("ic_stall", ic_stall, single && ic_miss && !dc_fin);
            expect_eq("dc_stall", dc_stall, single && dc_miss && !ic_fin);
            expect_eq("ic_flush", ic_flush, !single && ic_miss);
            expect_eq("dc_flush", dc_flush, !single && dc_miss);
            m_follow = (r5 && (is_load || (is_branch && cnt == 3))) || m_twice;
            m_twice  = r5 && is_load && nminor == 1;
            m_last   = exp_issue;
            if (taken) m_rem = pick;
            if (awvalid && wvalid && awready) begin  // register write accepted this edge
                if (awaddr == reg_active_off) m_active = wdata[3:0];
                if (awaddr == reg_primary_off) m_prim = wdata[1:0];
            end
        end
    end

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data,
                             input int hold, input logic [1:0] exp_resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(posedge clk);
        while (!awready) @(posedge clk);
        expect_eq("wready", wready, 1'b1);  // address and data taken together
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        expect_eq("bresp", bresp, exp_resp);
        repeat (hold) begin  // bready held low, response must stay
            @(negedge clk);
            expect_eq("bvalid", bvalid, 1'b1);
            expect_eq("bresp", bresp, exp_resp);
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, input int hold,
                            input logic [31:0] exp_data, input logic [1:0] exp_resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        repeat (hold + 1) begin
            expect_eq("rdata", rdata, exp_data);
            expect_eq("rresp", rresp, exp_resp);
            expect_eq("rvalid", rvalid, 1'b1);
            if (hold > 0) @(negedge clk);
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            {hart_kill, is_branch, is_load, ic_miss, ic_fin, dc_miss, dc_fin} = '0;
        end
    endtask

    task automatic pulse_decode(input logic branch, input logic load, input logic [1:0] id);
        @(negedge clk);
        is_branch   = branch;
        is_load     = load;
        decode_hart = id;
        idle_cycles(4);
    endtask

    task automatic close_test(input string name, input int e0);
        if (errors == e0) begin
            tests_passed++;
            $display("%s ok", name);
        end else begin
            tests_failed++;
            $display("%s %0d errors", name, errors - e0);
        end
    endtask

    task automatic register_access();
        int e0;
        e0 = errors;
        expect_eq("arready", arready, 1'b1);
        expect_eq("awready", awready, 1'b0);
        expect_eq("wready", wready, 1'b0);
        expect_eq("bvalid", bvalid, 1'b0);
        expect_eq("rvalid", rvalid, 1'b0);
        bus_write(reg_active_off, 32'h5, 2, resp_okay);
        bus_read(reg_active_off, 0, 32'h5, resp_okay);
        bus_write(reg_primary_off, 32'h2, 0, resp_okay);
        bus_read(reg_primary_off, 3, 32'h2, resp_okay);
        bus_read(reg_issue_off, 0, 32'h4, resp_okay);  // primary hart 2 alone issues
        bus_write(4'hc, 32'hf, 3, resp_slverr);
        bus_write(reg_issue_off, 32'h1, 0, resp_slverr);
        bus_read(4'hc, 2, 32'h0, resp_slverr);
        bus_read(reg_active_off, 0, 32'h5, resp_okay);
        close_test("register access", e0);
    endtask

    task automatic single_hart();
        int e0;
        e0 = errors;
        bus_write(reg_active_off, 32'h2, 0, resp_okay);
        bus_write(reg_primary_off, 32'h1, 0, resp_okay);
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            {ic_miss, ic_fin, dc_miss, dc_fin} = 4'(i);
        end
        idle_cycles(1);
        expect_eq("issue_hart", issue_hart, 4'b0010);
        bus_write(reg_active_off, 32'h0, 0, resp_okay);
        idle_cycles(2);
        expect_eq("issue_hart", issue_hart, 4'b0000);
        close_test("single hart", e0);
    endtask

    task automatic all_active_rotation();
        int e0;
        e0 = errors;
        bus_write(reg_active_off, 32'hf, 0, resp_okay);
        for (int i = 0; i < 8; i++) begin  // two full turns of the rotation
            @(negedge clk);
            {ic_miss, dc_miss, ic_fin} = 3'(i);
        end
        idle_cycles(1);
        close_test("all active", e0);
    endtask

    task automatic minor_pick_order();
        int e0;
        e0 = errors;
        bus_write(reg_active_off, 32'hb, 0, resp_okay);
        bus_write(reg_primary_off, 32'h1, 0, resp_okay);
        pulse_decode(1'b0, 1'b1, 2'd1);
        pulse_decode(1'b1, 1'b0, 2'd1);
        pulse_decode(1'b0, 1'b1, 2'd3);  // minor hart load, no hand-off
        bus_write(reg_active_off, 32'h3, 0, resp_okay);
        pulse_decode(1'b0, 1'b1, 2'd1);  // lone minor hart, two follow-ups
        pulse_decode(1'b1, 1'b0, 2'd1);
        close_test("minor picks", e0);
    endtask

    task automatic kill_and_random();
        int e0;
        logic [31:0] r;
        e0 = errors;
        bus_write(reg_active_off, 32'h7, 0, resp_okay);
        bus_write(reg_primary_off, 32'h2, 0, resp_okay);
        @(negedge clk);
        hart_kill = 1'b1;
        kill_hart = 2'd2;
        idle_cycles(3);
        repeat (200) begin
            @(negedge clk);
            r = $random(seed);
            {is_branch, is_load, ic_miss, ic_fin, dc_miss, dc_fin} = r[5:0];
            hart_kill   = (r[10:8] == 3'd0);
            kill_hart   = r[13:12];
            decode_hart = r[17:16];
        end
        idle_cycles(2);
        close_test("kill and random", e0);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        {awaddr, araddr, wdata, awvalid, wvalid, bready, arvalid, rready} = '0;
        wstrb = 4'hf;
        {hart_kill, is_branch, is_load, ic_miss, ic_fin, dc_miss, dc_fin} = '0;
        kill_hart   = '0;
        decode_hart = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        register_access();
        single_hart();
        all_active_rotation();
        minor_pick_order();
        kill_and_random();
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
